// File: src/pi1_pkg.sv
// ----------------------------------------------------------------------
// Peripheral bus definitions: widths, opcode encoding, the master's
// request and response, and the per-slot request and response structs
// ----------------------------------------------------------------------
`default_nettype none

package pi1_pkg;

	localparam int ARCH_W    = 32;
	localparam int ADDR_W    = 30;
	localparam int SEL_W     = ARCH_W / 8;
	localparam int REG_IDX_W = 4;

	// Value 3 is reserved
	typedef enum logic [1:0] {
		OP_NONE  = 2'b00,
		OP_WRITE = 2'b01,
		OP_READ  = 2'b10
	} pi1_op_e;

	// Held by the master until rdy is seen
	typedef struct packed {
		pi1_op_e             op;
		logic [ADDR_W-1:0]   addr;
		logic [ARCH_W-1:0]   data;
		logic [SEL_W-1:0]    sel;
	} pi1_req_t;

	typedef struct packed {
		logic                rdy;
		logic [ARCH_W-1:0]   data;
	} pi1_rsp_t;

	// One-cycle request to a single device
	typedef struct packed {
		logic                 valid;
		logic                 we;
		logic [REG_IDX_W-1:0] idx;
		logic [ARCH_W-1:0]    data;
		logic [SEL_W-1:0]     sel;
	} slot_req_t;

	typedef struct packed {
		logic                valid;
		logic [ARCH_W-1:0]   data;
	} slot_rsp_t;

endpackage

`default_nettype wire

// File: src/soc_map_pkg.sv
// ----------------------------------------------------------------------
// Peripheral address map: slot numbering and size, device ids,
// GPIO bank limits and register indexes of each device
// ----------------------------------------------------------------------
`default_nettype none

package soc_map_pkg;

	// Words per slot; slot number is the word address divided by this
	localparam int SLOT_WORDS = 16;

	// Bank k sits at SLOT_GPIO0 + k
	typedef enum logic [2:0] {
		SLOT_DEVTBL  = 3'd0,
		SLOT_INTCTRL = 3'd1,
		SLOT_GPIO0   = 3'd2
	} slot_e;

	localparam int GPIO_WIDTH     = 8;
	localparam int MAX_GPIO_BANKS = 4;

	localparam logic [7:0] DEVID_NONE    = 8'd0;
	localparam logic [7:0] DEVID_INTCTRL = 8'd3;
	localparam logic [7:0] DEVID_GPIO    = 8'd6;
	localparam logic [7:0] DEVID_DEVTBL  = 8'd7;

	localparam logic [3:0] DEVTBL_REG_COUNT = 4'd0;
	localparam logic [3:0] DEVTBL_REG_SWRST = 4'd15;

	localparam logic [3:0] INTC_REG_PENDING = 4'd0;
	localparam logic [3:0] INTC_REG_MASK    = 4'd1;
	localparam logic [3:0] INTC_REG_LOWEST  = 4'd2;

	localparam logic [3:0] GPIO_REG_OUT   = 4'd0;
	localparam logic [3:0] GPIO_REG_IN    = 4'd1;
	localparam logic [3:0] GPIO_REG_IEN   = 4'd2;
	localparam logic [3:0] GPIO_REG_FLAGS = 4'd3;

endpackage

`default_nettype wire

// File: src/pi1_router.sv
// ----------------------------------------------------------------------
// Request acceptance, slot decode and dispatch to the devices,
// with a default device that answers unmapped slots with zero
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module pi1_router #(
	parameter int unsigned GPIO_BANKS = 2
) (
	input  wire                                  clk_2x_w,
	input  wire                                  rst_p,
	input  wire pi1_pkg::pi1_req_t               req_i,
	input  wire                                  rdy_i,
	output pi1_pkg::slot_req_t                   devtbl_req_o,
	output pi1_pkg::slot_req_t                   intc_req_o,
	output pi1_pkg::slot_req_t [GPIO_BANKS-1:0]  gpio_req_o,
	output pi1_pkg::slot_rsp_t                   inv_rsp_o
);
	import pi1_pkg::*;
	import soc_map_pkg::*;

	localparam int IDX_BITS   = $clog2(SLOT_WORDS);
	localparam int SLOT_NUM_W = ADDR_W - IDX_BITS;

	logic [SLOT_NUM_W-1:0] slot_num;
	logic                  accept;
	logic                  hit_devtbl;
	logic                  hit_intc;
	logic [GPIO_BANKS-1:0] hit_gpio;

	logic                  busy_q;
	logic                  devtbl_vld_q;
	logic                  intc_vld_q;
	logic [GPIO_BANKS-1:0] gpio_vld_q;
	logic                  inv_pend_q;
	logic                  inv_vld_q;

	// Payload of the accepted request
	logic                  we_q;
	logic [REG_IDX_W-1:0]  idx_q;
	logic [ARCH_W-1:0]     data_q;
	logic [SEL_W-1:0]      sel_q;

	assign slot_num = req_i.addr[ADDR_W-1:IDX_BITS];

	// rdy_i high means the master is still looking at the old request
	assign accept = !busy_q && !rdy_i && (req_i.op != OP_NONE);

	always_comb begin
		hit_devtbl = (slot_num == SLOT_NUM_W'(SLOT_DEVTBL));
		hit_intc = (slot_num == SLOT_NUM_W'(SLOT_INTCTRL));
		for (int k = 0; k < GPIO_BANKS; k++) begin
			hit_gpio[k] = (slot_num == SLOT_NUM_W'(SLOT_GPIO0) + SLOT_NUM_W'(k));
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			busy_q <= 1'b0;
			devtbl_vld_q <= 1'b0;
			intc_vld_q <= 1'b0;
			gpio_vld_q <= '0;
			inv_pend_q <= 1'b0;
			inv_vld_q <= 1'b0;
		end else begin
			if (accept) begin
				busy_q <= 1'b1;
			end else if (rdy_i) begin
				busy_q <= 1'b0;
			end
			devtbl_vld_q <= accept && hit_devtbl;
			intc_vld_q <= accept && hit_intc;
			gpio_vld_q <= accept ? hit_gpio : '0;
			inv_pend_q <= accept && !(hit_devtbl || hit_intc || (|hit_gpio));
			// Default device takes one cycle like a real one
			inv_vld_q <= inv_pend_q;
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (accept) begin
			we_q <= (req_i.op == OP_WRITE);
			idx_q <= req_i.addr[REG_IDX_W-1:0];
			data_q <= req_i.data;
			sel_q <= req_i.sel;
		end
	end

	always_comb begin
		devtbl_req_o = '{valid: devtbl_vld_q, we: we_q, idx: idx_q, data: data_q, sel: sel_q};
		intc_req_o = '{valid: intc_vld_q, we: we_q, idx: idx_q, data: data_q, sel: sel_q};
		for (int k = 0; k < GPIO_BANKS; k++) begin
			gpio_req_o[k] = '{valid: gpio_vld_q[k], we: we_q, idx: idx_q,
				data: data_q, sel: sel_q};
		end
		inv_rsp_o = '{valid: inv_vld_q, data: '0};
	end

	// Nothing new is taken while a request is in flight, and its
	// ready comes back from the collector three edges after acceptance
	assert property (@(posedge clk_2x_w) disable iff (rst_p)
		accept |=> !accept ##1 !accept ##1 (rdy_i && !accept));

endmodule

`default_nettype wire

// File: src/gpio_bank.sv
// ----------------------------------------------------------------------
// One GPIO bank: output and enable registers, two-stage input
// synchronizer, change flags with write-1-to-clear and interrupt
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module gpio_bank (
	input  wire                                 clk_2x_w,
	input  wire                                 rst_p,
	input  wire                                 periph_rst_i,
	input  wire pi1_pkg::slot_req_t             req_i,
	output pi1_pkg::slot_rsp_t                  rsp_o,
	input  wire [soc_map_pkg::GPIO_WIDTH-1:0]   gp_i,
	output logic [soc_map_pkg::GPIO_WIDTH-1:0]  gp_o,
	output logic                                irq_o
);
	import pi1_pkg::*;
	import soc_map_pkg::*;

	logic                  clr;
	logic [ARCH_W-1:0]     wmask;
	logic [GPIO_WIDTH-1:0] wbits;
	logic [GPIO_WIDTH-1:0] wdata;
	logic                  wr_out;
	logic                  wr_ien;
	logic                  wr_flags;
	logic [GPIO_WIDTH-1:0] chg;
	logic [ARCH_W-1:0]     rdata;

	logic [GPIO_WIDTH-1:0] out_q;
	logic [GPIO_WIDTH-1:0] ien_q;
	logic [GPIO_WIDTH-1:0] flags_q;
	logic [GPIO_WIDTH-1:0] sync1_q;
	logic [GPIO_WIDTH-1:0] in_q;
	logic [GPIO_WIDTH-1:0] prev_q;
	logic                  irq_q;
	logic                  vld_q;
	logic [ARCH_W-1:0]     data_q;

	assign clr = rst_p | periph_rst_i;

	always_comb begin
		for (int b = 0; b < SEL_W; b++) begin
			wmask[b*8 +: 8] = {8{req_i.sel[b]}};
		end
	end

	assign wbits = wmask[GPIO_WIDTH-1:0];
	assign wdata = req_i.data[GPIO_WIDTH-1:0];
	assign wr_out = req_i.valid && req_i.we && (req_i.idx == GPIO_REG_OUT);
	assign wr_ien = req_i.valid && req_i.we && (req_i.idx == GPIO_REG_IEN);
	assign wr_flags = req_i.valid && req_i.we && (req_i.idx == GPIO_REG_FLAGS);

	// Only enabled pins raise a flag
	assign chg = (in_q ^ prev_q) & ien_q;

	always_comb begin
		rdata = '0;
		case (req_i.idx)
			GPIO_REG_OUT:   rdata[GPIO_WIDTH-1:0] = out_q;
			GPIO_REG_IN:    rdata[GPIO_WIDTH-1:0] = in_q;
			GPIO_REG_IEN:   rdata[GPIO_WIDTH-1:0] = ien_q;
			GPIO_REG_FLAGS: rdata[GPIO_WIDTH-1:0] = flags_q;
			default:        rdata = '0;
		endcase
	end

	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			sync1_q <= '0;
			in_q <= '0;
			prev_q <= '0;
		end else begin
			sync1_q <= gp_i;
			in_q <= sync1_q;
			prev_q <= in_q;
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (clr) begin
			out_q <= '0;
			ien_q <= '0;
			flags_q <= '0;
			irq_q <= 1'b0;
			vld_q <= 1'b0;
		end else begin
			if (wr_out) begin
				out_q <= (out_q & ~wbits) | (wdata & wbits);
			end
			if (wr_ien) begin
				ien_q <= (ien_q & ~wbits) | (wdata & wbits);
			end
			// A new change wins over a clear in the same cycle
			flags_q <= (flags_q & ~(wr_flags ? (wdata & wbits) : '0)) | chg;
			irq_q <= |flags_q;
			vld_q <= req_i.valid;
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (req_i.valid) begin
			data_q <= req_i.we ? '0 : rdata;
		end
	end

	assign rsp_o = '{valid: vld_q, data: data_q};
	assign gp_o = out_q;
	assign irq_o = irq_q;

endmodule

`default_nettype wire

// File: src/devtbl.sv
// ----------------------------------------------------------------------
// Read-only device table with slot count and per-slot entries,
// plus the software peripheral reset pulse
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module devtbl #(
	parameter int unsigned GPIO_BANKS = 2
) (
	input  wire                       clk_2x_w,
	input  wire                       rst_p,
	input  wire pi1_pkg::slot_req_t   req_i,
	output pi1_pkg::slot_rsp_t        rsp_o,
	output logic                      periph_rst_o
);
	import pi1_pkg::*;
	import soc_map_pkg::*;

	// Entry layout: id in 7:0, useintr in bit 8
	function automatic logic [ARCH_W-1:0] slot_entry(input logic [REG_IDX_W-1:0] slot);
		logic [7:0] id;
		logic       useintr;
		id = DEVID_NONE;
		useintr = 1'b0;
		if (slot == REG_IDX_W'(SLOT_DEVTBL)) begin
			id = DEVID_DEVTBL;
		end else if (slot == REG_IDX_W'(SLOT_INTCTRL)) begin
			id = DEVID_INTCTRL;
		end else if (slot >= REG_IDX_W'(SLOT_GPIO0) &&
			slot < REG_IDX_W'(SLOT_GPIO0) + REG_IDX_W'(GPIO_BANKS)) begin
			id = DEVID_GPIO;
			useintr = 1'b1;
		end
		return {{(ARCH_W-9){1'b0}}, useintr, id};
	endfunction

	logic [ARCH_W-1:0] rdata;
	logic              swrst;
	logic              vld_q;
	logic [ARCH_W-1:0] data_q;

	always_comb begin
		if (req_i.idx == DEVTBL_REG_COUNT) begin
			rdata = ARCH_W'(SLOT_GPIO0) + ARCH_W'(GPIO_BANKS);
		end else if (req_i.idx == DEVTBL_REG_SWRST) begin
			rdata = '0;
		end else begin
			rdata = slot_entry(req_i.idx - REG_IDX_W'(1));
		end
	end

	assign swrst = req_i.valid && req_i.we && (req_i.idx == DEVTBL_REG_SWRST) && req_i.data[0];

	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			vld_q <= 1'b0;
			periph_rst_o <= 1'b0;
		end else begin
			vld_q <= req_i.valid;
			// Pulse lines up with this write's response
			periph_rst_o <= swrst;
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (req_i.valid) begin
			data_q <= req_i.we ? '0 : rdata;
		end
	end

	assign rsp_o = '{valid: vld_q, data: data_q};

endmodule

`default_nettype wire

// File: src/intctrl.sv
// ----------------------------------------------------------------------
// Interrupt controller: registered bank lines, mask register,
// lowest pending unmasked source and the request line
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module intctrl #(
	parameter int unsigned GPIO_BANKS = 2
) (
	input  wire                       clk_2x_w,
	input  wire                       rst_p,
	input  wire                       periph_rst_i,
	input  wire pi1_pkg::slot_req_t   req_i,
	output pi1_pkg::slot_rsp_t        rsp_o,
	input  wire [GPIO_BANKS-1:0]      bank_irq_i,
	output logic                      irq_o
);
	import pi1_pkg::*;
	import soc_map_pkg::*;

	logic                  clr;
	logic                  wr_mask;
	logic [GPIO_BANKS-1:0] active;
	logic [ARCH_W-1:0]     lowest;
	logic [ARCH_W-1:0]     rdata;

	logic [GPIO_BANKS-1:0] pend_q;
	logic [GPIO_BANKS-1:0] mask_q;
	logic                  vld_q;
	logic [ARCH_W-1:0]     data_q;

	assign clr = rst_p | periph_rst_i;
	assign active = pend_q & mask_q;
	assign wr_mask = req_i.valid && req_i.we && (req_i.idx == INTC_REG_MASK) && req_i.sel[0];

	// All ones when nothing is pending
	always_comb begin
		lowest = '1;
		for (int k = GPIO_BANKS - 1; k >= 0; k--) begin
			if (active[k]) begin
				lowest = ARCH_W'(k);
			end
		end
	end

	always_comb begin
		rdata = '0;
		case (req_i.idx)
			INTC_REG_PENDING: rdata[GPIO_BANKS-1:0] = pend_q;
			INTC_REG_MASK:    rdata[GPIO_BANKS-1:0] = mask_q;
			INTC_REG_LOWEST:  rdata = lowest;
			default:          rdata = '0;
		endcase
	end

	always_ff @(posedge clk_2x_w) begin
		if (clr) begin
			pend_q <= '0;
			mask_q <= '0;
			vld_q <= 1'b0;
		end else begin
			pend_q <= bank_irq_i;
			if (wr_mask) begin
				mask_q <= req_i.data[GPIO_BANKS-1:0];
			end
			vld_q <= req_i.valid;
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (req_i.valid) begin
			data_q <= req_i.we ? '0 : rdata;
		end
	end

	assign rsp_o = '{valid: vld_q, data: data_q};
	assign irq_o = |active;

endmodule

`default_nettype wire

// File: src/pi1_collector.sv
// ----------------------------------------------------------------------
// Merges the device responses into the master's ready and read data
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module pi1_collector #(
	parameter int unsigned GPIO_BANKS = 2
) (
	input  wire                                       clk_2x_w,
	input  wire                                       rst_p,
	input  wire pi1_pkg::slot_rsp_t                   devtbl_rsp_i,
	input  wire pi1_pkg::slot_rsp_t                   intc_rsp_i,
	input  wire pi1_pkg::slot_rsp_t [GPIO_BANKS-1:0]  gpio_rsp_i,
	input  wire pi1_pkg::slot_rsp_t                   inv_rsp_i,
	output pi1_pkg::pi1_rsp_t                         rsp_o
);
	import pi1_pkg::*;

	logic [GPIO_BANKS-1:0] gpio_vld;
	logic                  any_vld;
	logic [ARCH_W-1:0]     any_data;
	logic                  rdy_q;
	logic [ARCH_W-1:0]     data_q;

	always_comb begin
		any_data = (devtbl_rsp_i.valid ? devtbl_rsp_i.data : '0) |
			(intc_rsp_i.valid ? intc_rsp_i.data : '0) |
			(inv_rsp_i.valid ? inv_rsp_i.data : '0);
		for (int k = 0; k < GPIO_BANKS; k++) begin
			gpio_vld[k] = gpio_rsp_i[k].valid;
			any_data = any_data | (gpio_rsp_i[k].valid ? gpio_rsp_i[k].data : '0);
		end
		any_vld = devtbl_rsp_i.valid | intc_rsp_i.valid | inv_rsp_i.valid | (|gpio_vld);
	end

	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			rdy_q <= 1'b0;
		end else begin
			rdy_q <= any_vld;
		end
	end

	always_ff @(posedge clk_2x_w) begin
		data_q <= any_data;
	end

	assign rsp_o = '{rdy: rdy_q, data: data_q};

	// The router dispatches to a single device per request
	assert property (@(posedge clk_2x_w) disable iff (rst_p)
		$onehot0({devtbl_rsp_i.valid, intc_rsp_i.valid, gpio_vld, inv_rsp_i.valid}));

endmodule

`default_nettype wire

// File: src/periph_fabric.sv
// ----------------------------------------------------------------------
// Peripheral fabric top: router, device table, interrupt controller,
// row of GPIO banks and response collector
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module periph_fabric #(
	parameter int unsigned GPIO_BANKS = 2
) (
	input  wire                                          clk_2x_w,
	input  wire                                          rst_p,
	input  wire pi1_pkg::pi1_req_t                       req_i,
	output pi1_pkg::pi1_rsp_t                            rsp_o,
	input  wire [GPIO_BANKS*soc_map_pkg::GPIO_WIDTH-1:0] gp_i,
	output wire [GPIO_BANKS*soc_map_pkg::GPIO_WIDTH-1:0] gp_o,
	output wire                                          irq_o
);
	import pi1_pkg::*;
	import soc_map_pkg::*;

	wire slot_req_t                  devtbl_req;
	wire slot_req_t                  intc_req;
	wire slot_req_t [GPIO_BANKS-1:0] gpio_req;
	wire slot_rsp_t                  devtbl_rsp;
	wire slot_rsp_t                  intc_rsp;
	wire slot_rsp_t [GPIO_BANKS-1:0] gpio_rsp;
	wire slot_rsp_t                  inv_rsp;
	wire [GPIO_BANKS-1:0]            bank_irq;
	wire                             periph_rst;

	pi1_router #(.GPIO_BANKS(GPIO_BANKS)) u_router (
		.clk_2x_w     (clk_2x_w),
		.rst_p        (rst_p),
		.req_i        (req_i),
		.rdy_i        (rsp_o.rdy),
		.devtbl_req_o (devtbl_req),
		.intc_req_o   (intc_req),
		.gpio_req_o   (gpio_req),
		.inv_rsp_o    (inv_rsp)
	);

	devtbl #(.GPIO_BANKS(GPIO_BANKS)) u_devtbl (
		.clk_2x_w     (clk_2x_w),
		.rst_p        (rst_p),
		.req_i        (devtbl_req),
		.rsp_o        (devtbl_rsp),
		.periph_rst_o (periph_rst)
	);

	intctrl #(.GPIO_BANKS(GPIO_BANKS)) u_intctrl (
		.clk_2x_w     (clk_2x_w),
		.rst_p        (rst_p),
		.periph_rst_i (periph_rst),
		.req_i        (intc_req),
		.rsp_o        (intc_rsp),
		.bank_irq_i   (bank_irq),
		.irq_o        (irq_o)
	);

	for (genvar k = 0; k < GPIO_BANKS; k++) begin : g_bank
		gpio_bank u_bank (
			.clk_2x_w     (clk_2x_w),
			.rst_p        (rst_p),
			.periph_rst_i (periph_rst),
			.req_i        (gpio_req[k]),
			.rsp_o        (gpio_rsp[k]),
			.gp_i         (gp_i[k*GPIO_WIDTH +: GPIO_WIDTH]),
			.gp_o         (gp_o[k*GPIO_WIDTH +: GPIO_WIDTH]),
			.irq_o        (bank_irq[k])
		);
	end

	pi1_collector #(.GPIO_BANKS(GPIO_BANKS)) u_collector (
		.clk_2x_w     (clk_2x_w),
		.rst_p        (rst_p),
		.devtbl_rsp_i (devtbl_rsp),
		.intc_rsp_i   (intc_rsp),
		.gpio_rsp_i   (gpio_rsp),
		.inv_rsp_i    (inv_rsp),
		.rsp_o        (rsp_o)
	);

endmodule

`default_nettype wire

// File: tb/periph_model.svh
// ----------------------------------------------------------------------
// Reference model of the fabric state: GPIO output, enable and flag
// registers, interrupt mask, last applied pins and expected reads
// ----------------------------------------------------------------------
`ifndef PERIPH_MODEL_SVH
`define PERIPH_MODEL_SVH

logic [GPIO_WIDTH-1:0] m_out   [GPIO_BANKS];
logic [GPIO_WIDTH-1:0] m_ien   [GPIO_BANKS];
logic [GPIO_WIDTH-1:0] m_flags [GPIO_BANKS];
logic [GPIO_WIDTH-1:0] m_pins  [GPIO_BANKS];
logic [GPIO_BANKS-1:0] m_mask;

// Peripheral reset leaves the pins alone
function automatic void model_periph_reset();
	for (int k = 0; k < GPIO_BANKS; k++) begin
		m_out[k] = '0;
		m_ien[k] = '0;
		m_flags[k] = '0;
	end
	m_mask = '0;
endfunction

function automatic void model_power_on();
	model_periph_reset();
	for (int k = 0; k < GPIO_BANKS; k++) begin
		m_pins[k] = '0;
	end
endfunction

// A pin that toggles while enabled latches its flag
function automatic void model_pins(input logic [GPIO_BANKS*GPIO_WIDTH-1:0] pin_vals);
	logic [GPIO_WIDTH-1:0] nv;
	for (int k = 0; k < GPIO_BANKS; k++) begin
		nv = pin_vals[k*GPIO_WIDTH +: GPIO_WIDTH];
		m_flags[k] = m_flags[k] | ((m_pins[k] ^ nv) & m_ien[k]);
		m_pins[k] = nv;
	end
endfunction

function automatic logic [GPIO_BANKS-1:0] model_pending();
	logic [GPIO_BANKS-1:0] p;
	for (int k = 0; k < GPIO_BANKS; k++) begin
		p[k] = |m_flags[k];
	end
	return p;
endfunction

function automatic logic [31:0] model_lowest();
	logic [GPIO_BANKS-1:0] act;
	logic [31:0]           low;
	act = model_pending() & m_mask;
	low = 32'hffff_ffff;
	for (int k = 0; k < GPIO_BANKS; k++) begin
		if (act[k] && low == 32'hffff_ffff) begin
			low = 32'(k);
		end
	end
	return low;
endfunction

function automatic logic model_irq();
	return |(model_pending() & m_mask);
endfunction

function automatic logic [GPIO_BANKS*GPIO_WIDTH-1:0] model_gp_o();
	logic [GPIO_BANKS*GPIO_WIDTH-1:0] v;
	for (int k = 0; k < GPIO_BANKS; k++) begin
		v[k*GPIO_WIDTH +: GPIO_WIDTH] = m_out[k];
	end
	return v;
endfunction

// Slot number sits above the 4 register index bits
function automatic logic [31:0] model_read(input logic [ADDR_W-1:0] a);
	int          slot;
	int          ent;
	int          b;
	logic [31:0] val;
	slot = int'(a[ADDR_W-1:4]);
	ent = int'(a[3:0]) - 1;
	b = slot - int'(SLOT_GPIO0);
	val = '0;
	if (slot == int'(SLOT_DEVTBL)) begin
		if (a[3:0] == DEVTBL_REG_COUNT) begin
			val = 32'(2 + GPIO_BANKS);
		end else if (a[3:0] == DEVTBL_REG_SWRST) begin
			val = '0;
		end else if (ent == int'(SLOT_DEVTBL)) begin
			val = {24'h0, DEVID_DEVTBL};
		end else if (ent == int'(SLOT_INTCTRL)) begin
			val = {24'h0, DEVID_INTCTRL};
		end else if (ent < int'(SLOT_GPIO0) + GPIO_BANKS) begin
			val = {23'h0, 1'b1, DEVID_GPIO};
		end else begin
			val = {24'h0, DEVID_NONE};
		end
	end else if (slot == int'(SLOT_INTCTRL)) begin
		case (a[3:0])
			INTC_REG_PENDING: val = 32'(model_pending());
			INTC_REG_MASK:    val = 32'(m_mask);
			INTC_REG_LOWEST:  val = model_lowest();
			default:          val = '0;
		endcase
	end else if (b >= 0 && b < GPIO_BANKS) begin
		case (a[3:0])
			GPIO_REG_OUT:   val = 32'(m_out[b]);
			GPIO_REG_IN:    val = 32'(m_pins[b]);
			GPIO_REG_IEN:   val = 32'(m_ien[b]);
			GPIO_REG_FLAGS: val = 32'(m_flags[b]);
			default:        val = '0;
		endcase
	end
	return val;
endfunction

// Banks are 8 bits wide so only byte select 0 matters
function automatic void model_write(input logic [ADDR_W-1:0] a, input logic [31:0] d,
		input logic [3:0] s);
	int slot;
	int b;
	slot = int'(a[ADDR_W-1:4]);
	b = slot - int'(SLOT_GPIO0);
	if (slot == int'(SLOT_DEVTBL) && a[3:0] == DEVTBL_REG_SWRST && d[0]) begin
		model_periph_reset();
	end else if (slot == int'(SLOT_INTCTRL) && a[3:0] == INTC_REG_MASK && s[0]) begin
		m_mask = d[GPIO_BANKS-1:0];
	end else if (b >= 0 && b < GPIO_BANKS && s[0]) begin
		case (a[3:0])
			GPIO_REG_OUT:   m_out[b] = d[GPIO_WIDTH-1:0];
			GPIO_REG_IEN:   m_ien[b] = d[GPIO_WIDTH-1:0];
			GPIO_REG_FLAGS: m_flags[b] = m_flags[b] & ~d[GPIO_WIDTH-1:0];
			default:        m_out[b] = m_out[b];
		endcase
	end
endfunction

`endif

// File: tb/tb_periph_fabric.sv
// ----------------------------------------------------------------------
// Testbench for the peripheral fabric: clock and reset, LCG stimulus,
// bus access tasks, checks against the register model and verdict
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_periph_fabric;
	import pi1_pkg::*;
	import soc_map_pkg::*;

	localparam int GPIO_BANKS  = 2;
	localparam int PIN_W       = GPIO_BANKS * GPIO_WIDTH;
	localparam int BUS_TIMEOUT = 20;

	logic              clk_2x_w = 1'b0;
	logic              rst_p;
	pi1_req_t          req;
	pi1_rsp_t          rsp;
	logic [PIN_W-1:0]  gp_i;
	wire  [PIN_W-1:0]  gp_o;
	wire               irq;

	logic [31:0]       lcg_state;
	logic [31:0]       rnd;
	logic [PIN_W-1:0]  pins;
	logic [3:0]        idx;
	int                bank;

	`include "periph_model.svh"

	periph_fabric #(.GPIO_BANKS(GPIO_BANKS)) u_dut (
		.clk_2x_w (clk_2x_w),
		.rst_p    (rst_p),
		.req_i    (req),
		.rsp_o    (rsp),
		.gp_i     (gp_i),
		.gp_o     (gp_o),
		.irq_o    (irq)
	);

	always #20 clk_2x_w = ~clk_2x_w;

	// Low LCG bits repeat quickly so the high half is folded in
	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state ^ (lcg_state >> 16);
	endfunction

	function automatic logic [ADDR_W-1:0] reg_addr(input int slot, input logic [3:0] ridx);
		return ADDR_W'(slot * SLOT_WORDS) | ADDR_W'(ridx);
	endfunction

	task automatic stop_run();
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
			stop_run();
		end
	endtask

	// Called just after a rising edge, which becomes edge P of the request
	task automatic bus_access(input pi1_op_e opcode, input logic [ADDR_W-1:0] a,
			input logic [31:0] wdata, input logic [3:0] sel, output logic [31:0] rd);
		int   cnt;
		logic seen;
		cnt = 0;
		seen = 1'b0;
		rd = '0;
		req <= '{op: opcode, addr: a, data: wdata, sel: sel};
		while (!seen && cnt < BUS_TIMEOUT) begin
			@(posedge clk_2x_w);
			cnt++;
			if (rsp.rdy) begin
				seen = 1'b1;
				rd = rsp.data;
			end
		end
		if (!seen) begin
			$display("Timeout: no ready from the bus for address 0x%08h", a);
			stop_run();
		end
		req <= '0;
		// Ready was raised one edge before the one that saw it
		check_val("rdy_o latency", 32'(cnt - 1), 32'd3);
		@(posedge clk_2x_w);
		check_val("rdy_o width", {31'h0, rsp.rdy}, 32'd0);
	endtask

	task automatic check_read(input logic [ADDR_W-1:0] a);
		logic [31:0] rd;
		bus_access(OP_READ, a, '0, '0, rd);
		check_val($sformatf("rsp_o.data at 0x%08h", a), rd, model_read(a));
	endtask

	task automatic do_write(input logic [ADDR_W-1:0] a, input logic [31:0] d,
			input logic [3:0] sel);
		logic [31:0] rd;
		bus_access(OP_WRITE, a, d, sel, rd);
		check_val("rsp_o.data on write", rd, 32'd0);
		model_write(a, d, sel);
	endtask

	task automatic check_intc();
		check_read(reg_addr(int'(SLOT_INTCTRL), INTC_REG_PENDING));
		check_read(reg_addr(int'(SLOT_INTCTRL), INTC_REG_MASK));
		check_read(reg_addr(int'(SLOT_INTCTRL), INTC_REG_LOWEST));
		check_val("irq_o", {31'h0, irq}, {31'h0, model_irq()});
	endtask

	initial begin
		lcg_state = 32'h4e3f;
		rst_p = 1'b1;
		req = '0;
		gp_i = '0;
		model_power_on();
		repeat (5) @(posedge clk_2x_w);
		rst_p <= 1'b0;
		@(posedge clk_2x_w);
		check_val("rdy_o", {31'h0, rsp.rdy}, 32'd0);
		check_val("irq_o", {31'h0, irq}, 32'd0);
		check_val("gp_o", 32'(gp_o), 32'd0);

		// Device table, then slots past the last bank
		for (int i = 0; i < SLOT_WORDS; i++) begin
			check_read(reg_addr(int'(SLOT_DEVTBL), 4'(i)));
		end
		for (int i = 0; i < 6; i++) begin
			rnd = next_rand();
			check_read(reg_addr(int'(SLOT_GPIO0) + GPIO_BANKS + int'(rnd[20:4]), rnd[3:0]));
		end
		do_write(reg_addr(int'(SLOT_GPIO0) + GPIO_BANKS + 3, 4'd2), next_rand(), 4'hf);

		// OUT and IEN with random byte selects
		for (int i = 0; i < 40; i++) begin
			rnd = next_rand();
			bank = int'(rnd[3:0]) % GPIO_BANKS;
			idx = rnd[4] ? GPIO_REG_IEN : GPIO_REG_OUT;
			do_write(reg_addr(int'(SLOT_GPIO0) + bank, idx), next_rand(), rnd[11:8]);
			check_read(reg_addr(int'(SLOT_GPIO0) + bank, idx));
			check_val("gp_o", 32'(gp_o), 32'(model_gp_o()));
		end

		// Pin changes, flags, mask and interrupt state
		for (int r = 0; r < 16; r++) begin
			for (int k = 0; k < GPIO_BANKS; k++) begin
				rnd = next_rand();
				if (rnd[5]) begin
					do_write(reg_addr(int'(SLOT_GPIO0) + k, GPIO_REG_IEN), next_rand(), 4'h1);
				end
			end
			pins = PIN_W'(next_rand());
			gp_i <= pins;
			model_pins(pins);
			repeat (10) @(posedge clk_2x_w);
			for (int k = 0; k < GPIO_BANKS; k++) begin
				check_read(reg_addr(int'(SLOT_GPIO0) + k, GPIO_REG_IN));
				check_read(reg_addr(int'(SLOT_GPIO0) + k, GPIO_REG_FLAGS));
			end
			rnd = next_rand();
			do_write(reg_addr(int'(SLOT_INTCTRL), INTC_REG_MASK), next_rand(), rnd[3:0]);
			check_intc();
			rnd = next_rand();
			bank = int'(rnd[7:4]) % GPIO_BANKS;
			do_write(reg_addr(int'(SLOT_GPIO0) + bank, GPIO_REG_FLAGS), next_rand(),
				{rnd[3:1], 1'b1});
			check_read(reg_addr(int'(SLOT_GPIO0) + bank, GPIO_REG_FLAGS));
			check_intc();
		end

		// Load some state, then the software reset
		do_write(reg_addr(int'(SLOT_GPIO0), GPIO_REG_OUT), next_rand() | 32'h1, 4'h1);
		do_write(reg_addr(int'(SLOT_GPIO0), GPIO_REG_IEN), 32'hff, 4'h1);
		do_write(reg_addr(int'(SLOT_INTCTRL), INTC_REG_MASK), 32'hf, 4'h1);
		pins = ~pins;
		gp_i <= pins;
		model_pins(pins);
		repeat (10) @(posedge clk_2x_w);
		check_intc();
		do_write(reg_addr(int'(SLOT_DEVTBL), DEVTBL_REG_SWRST), 32'h1, 4'hf);
		check_val("gp_o", 32'(gp_o), 32'd0);
		check_val("irq_o", {31'h0, irq}, 32'd0);
		for (int k = 0; k < GPIO_BANKS; k++) begin
			check_read(reg_addr(int'(SLOT_GPIO0) + k, GPIO_REG_OUT));
			check_read(reg_addr(int'(SLOT_GPIO0) + k, GPIO_REG_IEN));
			check_read(reg_addr(int'(SLOT_GPIO0) + k, GPIO_REG_FLAGS));
		end
		check_intc();

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+tb
src/pi1_pkg.sv
src/soc_map_pkg.sv
src/pi1_router.sv
src/gpio_bank.sv
src/devtbl.sv
src/intctrl.sv
src/pi1_collector.sv
src/periph_fabric.sv
tb/tb_periph_fabric.sv

// File: Makefile
# Verilator build and run of the peripheral fabric testbench

SIM  := obj_dir/Vtb_periph_fabric
SRCS := $(wildcard src/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) build.f
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_periph_fabric -f build.f

# Pass or fail comes from the log, not the exit code
run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -qx "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log
